//--- logic/pitch_params.svh
`ifndef PITCH_PARAMS_SVH
`define PITCH_PARAMS_SVH

// Frame and sample geometry
`define FFT_NSAMPLES 64 // Bins per FFT frame, power of two
`define FFT_W 16 // Signed real/imag width from the FFT core

// Magnitude to display level
`define PEAK_SHIFT 16
`define PEAK_THRESHOLD 210 // Below this the frame counts as silence

// Detection windows, bounds are exclusive
`define LOWER_WHISTLE 20
`define UPPER_WHISTLE 28
`define LOWER_BEEP 5
`define UPPER_BEEP 12

`endif

//--- logic/pitch_pkg.sv
`default_nettype none

`include "pitch_params.svh"

package pitch_pkg;

	typedef logic signed [`FFT_W-1:0] sample_t; // One real or imag part
	typedef logic [31:0] mag_t; // re^2 + im^2, no overflow for 16-bit parts
	typedef logic [$clog2(`FFT_NSAMPLES)-1:0] bin_t;
	typedef logic [7:0] level_t; // Saturated magnitude for display

	// Debug read port
	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	typedef enum logic {
		rd_idle, // Waiting for an address
		rd_resp // Holding data until rready
	} rd_state_t;

endpackage

`default_nettype wire

//--- logic/fft_mag_sq.sv
`default_nettype none

`include "pitch_params.svh"

module fft_mag_sq import pitch_pkg::*; (
	input wire logic fft_clk,
	input wire logic reset,
	input wire logic do_en,
	input wire sample_t do_re,
	input wire sample_t do_im,
	output logic mag_valid,
	output mag_t mag,
	output bin_t mag_bin,
	output logic mag_last
);
	bin_t bin_cnt; // Index of the next bin from the FFT
	logic cnt_end;

	// Stage 1 registers
	mag_t re_sq;
	mag_t im_sq;
	logic sq_valid;
	logic sq_last;
	bin_t sq_bin;

	assign cnt_end = (bin_cnt == bin_t'(`FFT_NSAMPLES - 1));

	// Control path, counter and valid/last pipeline
	always_ff @(posedge fft_clk or posedge reset) begin
		if (reset) begin
			bin_cnt <= '0;
			sq_valid <= 1'b0;
			sq_last <= 1'b0;
			mag_valid <= 1'b0;
			mag_last <= 1'b0;
		end else begin
			if (do_en)
				bin_cnt <= cnt_end ? '0 : bin_cnt + 1'b1; // Wrap at frame end
			sq_valid <= do_en;
			sq_last <= do_en && cnt_end; // Last bin of the frame
			mag_valid <= sq_valid;
			mag_last <= sq_last;
		end
	end

	// Data path, squares then sum
	always_ff @(posedge fft_clk) begin
		re_sq <= do_re * do_re; // Operands sign-extended to 32 bits
		im_sq <= do_im * do_im;
		sq_bin <= bin_cnt; // Index rides along with the data
		mag <= re_sq + im_sq;
		mag_bin <= sq_bin;
	end

endmodule

`default_nettype wire

//--- logic/fft_output_buffer.sv
`default_nettype none

`include "pitch_params.svh"

module fft_output_buffer import pitch_pkg::*; (
	input wire logic fft_clk,
	input wire logic reset,

	// Magnitude stream from the producer
	input wire logic mag_valid,
	input wire mag_t mag,
	input wire bin_t mag_bin,
	input wire logic mag_last,

	// AXI4-Lite read channels
	input wire axi_addr_t araddr,
	input wire logic arvalid,
	output logic arready,
	output logic rvalid,
	input wire logic rready,
	output axi_data_t rdata,
	output axi_resp_t rresp
);
	localparam int BIN_W = $bits(bin_t);
	localparam int BYTES = 4 * `FFT_NSAMPLES; // Address span of one frame

	// Two banks, MSB of the address picks the bank
	mag_t mem [2*`FFT_NSAMPLES];

	logic wr_bank; // Bank being filled, the other one is complete
	logic frame_ready; // At least one whole frame stored

	rd_state_t rd_state;
	logic ar_fire;
	logic addr_bad;
	bin_t rd_bin;

	// Write side

	always_ff @(posedge fft_clk) begin
		if (mag_valid)
			mem[{wr_bank, mag_bin}] <= mag;
	end

	// Swap banks on the last bin
	always_ff @(posedge fft_clk or posedge reset) begin
		if (reset) begin
			wr_bank <= 1'b0;
			frame_ready <= 1'b0;
		end else if (mag_valid && mag_last) begin
			wr_bank <= ~wr_bank;
			frame_ready <= 1'b1;
		end
	end

	// Read side

	assign arready = (rd_state == rd_idle);
	assign rvalid = (rd_state == rd_resp);
	assign ar_fire = arvalid && arready;

	assign rd_bin = araddr[2 +: BIN_W]; // Word address, byte lanes ignored
	assign addr_bad = (int'(araddr) >= BYTES) || !frame_ready;

	always_ff @(posedge fft_clk or posedge reset) begin
		if (reset) begin
			rd_state <= rd_idle;
		end else begin
			unique case (rd_state)
				rd_idle: begin
					if (arvalid)
						rd_state <= rd_resp;
				end
				rd_resp: begin
					if (rready) // Hold under back-pressure
						rd_state <= rd_idle;
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// Data and response latched at the address handshake
	// Later bank swaps leave them alone
	always_ff @(posedge fft_clk) begin
		if (ar_fire) begin
			if (addr_bad) begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end else begin
				rdata <= mem[{~wr_bank, rd_bin}]; // Completed bank
				rresp <= RESP_OKAY;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/fft_find_peak.sv
`default_nettype none

`include "pitch_params.svh"

module fft_find_peak import pitch_pkg::*; (
	input wire logic fft_clk,
	input wire logic reset,
	input wire logic mag_valid,
	input wire mag_t mag,
	input wire bin_t mag_bin,
	input wire logic mag_last,
	output logic peak_valid,
	output mag_t peak_mag,
	output bin_t peak_bin
);
	localparam bin_t HALF = bin_t'(`FFT_NSAMPLES / 2);

	mag_t max_mag; // Running maximum of this frame
	bin_t max_bin;

	// Maximum including the current bin
	mag_t cand_mag;
	bin_t cand_bin;

	always_comb begin
		cand_mag = max_mag;
		cand_bin = max_bin;
		if (mag_bin == '0) begin
			cand_mag = mag; // First bin restarts the search
			cand_bin = '0;
		end else if (mag_bin < HALF && mag > max_mag) begin
			cand_mag = mag; // Strictly greater, so ties keep the lower bin
			cand_bin = mag_bin;
		end
	end

	always_ff @(posedge fft_clk or posedge reset) begin
		if (reset) begin
			max_mag <= '0;
			max_bin <= '0;
			peak_valid <= 1'b0;
		end else begin
			peak_valid <= mag_valid && mag_last; // Pulse after the last bin
			if (mag_valid) begin
				if (mag_last) begin
					max_mag <= '0;
					max_bin <= '0;
				end else begin
					max_mag <= cand_mag;
					max_bin <= cand_bin;
				end
			end
		end
	end

	// Frame result
	always_ff @(posedge fft_clk) begin
		if (mag_valid && mag_last) begin
			peak_mag <= cand_mag;
			peak_bin <= cand_bin;
		end
	end

endmodule

`default_nettype wire

//--- logic/pitch_classifier.sv
`default_nettype none

`include "pitch_params.svh"

module pitch_classifier import pitch_pkg::*; (
	input wire logic fft_clk,
	input wire logic reset,
	input wire logic peak_valid,
	input wire mag_t peak_mag,
	input wire bin_t peak_bin,
	output logic pitch_valid,
	output bin_t pitch_bin,
	output level_t peak_level,
	output logic whistle_detected,
	output logic beep_detected
);
	mag_t shifted;
	level_t level; // Saturated to 8 bits
	logic loud;
	bin_t sel_bin; // Bin after the silence check
	logic in_whistle;
	logic in_beep;

	assign shifted = peak_mag >> `PEAK_SHIFT;
	assign level = (shifted > mag_t'(255)) ? 8'hFF : level_t'(shifted);
	assign loud = (int'(level) >= `PEAK_THRESHOLD);
	assign sel_bin = loud ? peak_bin : '0; // Silence reports bin 0

	// Ranges checked on this frame's bin
	assign in_whistle = (int'(sel_bin) > `LOWER_WHISTLE) && (int'(sel_bin) < `UPPER_WHISTLE);
	assign in_beep = (int'(sel_bin) > `LOWER_BEEP) && (int'(sel_bin) < `UPPER_BEEP);

	always_ff @(posedge fft_clk or posedge reset) begin
		if (reset) begin
			pitch_valid <= 1'b0;
			pitch_bin <= '0;
			peak_level <= '0;
			whistle_detected <= 1'b0;
			beep_detected <= 1'b0;
		end else begin
			pitch_valid <= peak_valid;
			whistle_detected <= peak_valid && in_whistle; // One cycle pulses
			beep_detected <= peak_valid && in_beep;
			if (peak_valid) begin
				pitch_bin <= sel_bin;
				peak_level <= level; // Held until the next frame
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/fft_pitch_detect.sv
`default_nettype none

`include "pitch_params.svh"

module fft_pitch_detect import pitch_pkg::*; (
	input wire logic fft_clk,
	input wire logic reset,

	// FFT core output, cannot stall
	input wire logic do_en,
	input wire sample_t do_re,
	input wire sample_t do_im,

	// Debug readout of the last frame
	input wire axi_addr_t araddr,
	input wire logic arvalid,
	output logic arready,
	output logic rvalid,
	input wire logic rready,
	output axi_data_t rdata,
	output axi_resp_t rresp,

	// Pitch results, one per frame
	output logic pitch_valid,
	output bin_t pitch_bin,
	output level_t peak_level,
	output logic whistle_detected,
	output logic beep_detected
);
	logic mag_valid;
	mag_t mag;
	bin_t mag_bin;
	logic mag_last;

	logic peak_valid;
	mag_t peak_mag;
	bin_t peak_bin;

	fft_mag_sq i_mag_sq (
		.fft_clk (fft_clk),
		.reset (reset),
		.do_en (do_en),
		.do_re (do_re),
		.do_im (do_im),
		.mag_valid (mag_valid),
		.mag (mag),
		.mag_bin (mag_bin),
		.mag_last (mag_last)
	);

	fft_output_buffer i_output_buffer (
		.fft_clk (fft_clk),
		.reset (reset),
		.mag_valid (mag_valid),
		.mag (mag),
		.mag_bin (mag_bin),
		.mag_last (mag_last),
		.araddr (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rvalid (rvalid),
		.rready (rready),
		.rdata (rdata),
		.rresp (rresp)
	);

	fft_find_peak i_find_peak (
		.fft_clk (fft_clk),
		.reset (reset),
		.mag_valid (mag_valid),
		.mag (mag),
		.mag_bin (mag_bin),
		.mag_last (mag_last),
		.peak_valid (peak_valid),
		.peak_mag (peak_mag),
		.peak_bin (peak_bin)
	);

	pitch_classifier i_classifier (
		.fft_clk (fft_clk),
		.reset (reset),
		.peak_valid (peak_valid),
		.peak_mag (peak_mag),
		.peak_bin (peak_bin),
		.pitch_valid (pitch_valid),
		.pitch_bin (pitch_bin),
		.peak_level (peak_level),
		.whistle_detected (whistle_detected),
		.beep_detected (beep_detected)
	);

endmodule

`default_nettype wire

//--- test/tb_pitch_checks.svh
`ifndef TB_PITCH_CHECKS_SVH
`define TB_PITCH_CHECKS_SVH

// Squared magnitude of one bin
function automatic mag_t ref_mag(input sample_t re, input sample_t im);
	int r;
	int i;
	r = re;
	i = im;
	return mag_t'(r * r) + mag_t'(i * i); // Each square fits in 31 bits
endfunction

// Strongest bin of frame_mag in the lower half of the frame
function automatic bin_t ref_peak(output mag_t peak);
	bin_t best;
	best = '0;
	peak = frame_mag[0];
	for (int b = 1; b < `FFT_NSAMPLES / 2; b++) begin
		if (frame_mag[b] > peak) begin // Equal values keep the lower bin
			peak = frame_mag[b];
			best = bin_t'(b);
		end
	end
	return best;
endfunction

function automatic level_t ref_level(input mag_t m);
	mag_t shifted;
	shifted = m >> `PEAK_SHIFT;
	return (shifted > 255) ? level_t'(255) : level_t'(shifted); // Saturate at 8 bits
endfunction

// Quiet frames report bin 0
function automatic bin_t ref_pitch(input bin_t peak_bin, input level_t level);
	return (int'(level) >= `PEAK_THRESHOLD) ? peak_bin : bin_t'(0);
endfunction

// Detection windows exclude their bounds
function automatic logic strictly_inside(input bin_t b, input int lo, input int hi);
	return (int'(b) > lo) && (int'(b) < hi);
endfunction

task automatic check_bin(input string name, input bin_t exp, input bin_t act);
	if (act !== exp)
		stop_with_failure($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_level(input string name, input level_t exp, input level_t act);
	if (act !== exp)
		stop_with_failure($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
		stop_with_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
	if (act !== exp) // Magnitudes in hex
		stop_with_failure($sformatf("error %s: expected 0x%08h, actual 0x%08h", name, exp, act));
endtask

task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
	if (act !== exp)
		stop_with_failure($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
endtask

`endif

//--- test/tb_fft_pitch_detect.sv
`default_nettype none

`include "pitch_params.svh"

module tb_fft_pitch_detect import pitch_pkg::*; ();
	localparam int PERIOD = 100;
	localparam int DRIVE_DELAY = 10; // Inputs move after the rising edge
	localparam int NUM_FRAMES = 20; // Upper bound on frames sent
	localparam int MAX_GAP = 3; // Longest do_en gap in the random frames
	localparam int READ_CYCLES = 400; // Readout and back-pressure budget
	localparam int TIMEOUT =
		2 * (NUM_FRAMES * `FFT_NSAMPLES * (MAX_GAP + 1) + READ_CYCLES) * PERIOD;

	logic fft_clk;
	logic reset;
	logic do_en;
	sample_t do_re;
	sample_t do_im;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic pitch_valid;
	bin_t pitch_bin;
	level_t peak_level;
	logic whistle_detected;
	logic beep_detected;

	sample_t frame_re [`FFT_NSAMPLES]; // Frame being built
	sample_t frame_im [`FFT_NSAMPLES];
	mag_t frame_mag [`FFT_NSAMPLES]; // Magnitudes of the frame last sent

	// Expected results per frame in send order
	string exp_name [$];
	bin_t exp_bin [$];
	level_t exp_level [$];
	logic exp_whistle [$];
	logic exp_beep [$];

	fft_pitch_detect i_dut (.*);

	initial fft_clk = 1'b0;
	always #(PERIOD / 2) fft_clk = ~fft_clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	`include "tb_pitch_checks.svh"

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge fft_clk);
			#DRIVE_DELAY;
			do_en = 1'b0;
		end
	endtask

	// Small random bins around zero
	task automatic fill_noise(input int amp);
		for (int i = 0; i < `FFT_NSAMPLES; i++) begin
			frame_re[i] = sample_t'(int'($urandom_range(2 * amp)) - amp);
			frame_im[i] = sample_t'(int'($urandom_range(2 * amp)) - amp);
		end
	endtask

	task automatic place_tone(input int b, input int re, input int im);
		frame_re[b] = sample_t'(re);
		frame_im[b] = sample_t'(im);
	endtask

	// Queue the expected result, then stream the bins like the FFT core
	task automatic send_frame(input string name, input int max_gap);
		mag_t peak;
		bin_t peak_bin;
		level_t level;
		bin_t pitch;
		for (int i = 0; i < `FFT_NSAMPLES; i++)
			frame_mag[i] = ref_mag(frame_re[i], frame_im[i]);
		peak_bin = ref_peak(peak);
		level = ref_level(peak);
		pitch = ref_pitch(peak_bin, level);
		exp_name.push_back(name);
		exp_bin.push_back(pitch);
		exp_level.push_back(level);
		exp_whistle.push_back(strictly_inside(pitch, `LOWER_WHISTLE, `UPPER_WHISTLE));
		exp_beep.push_back(strictly_inside(pitch, `LOWER_BEEP, `UPPER_BEEP));
		for (int i = 0; i < `FFT_NSAMPLES; i++) begin
			idle_cycles($urandom_range(max_gap)); // Gap before this bin
			@(posedge fft_clk);
			#DRIVE_DELAY;
			do_en = 1'b1;
			do_re = frame_re[i];
			do_im = frame_im[i];
		end
		// do_en stays high until the caller ends the stream
	endtask

	// One AXI4-Lite read with rready held low for hold cycles
	task automatic read_and_check(input string name, input axi_addr_t addr, input int hold,
			input axi_data_t exp_data, input axi_resp_t exp_resp);
		@(posedge fft_clk);
		#DRIVE_DELAY;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge fft_clk);
		while (!arready)
			@(negedge fft_clk);
		@(posedge fft_clk); // Address transfer
		#DRIVE_DELAY;
		arvalid = 1'b0;
		@(negedge fft_clk);
		check_flag({name, " rvalid"}, 1'b1, rvalid);
		check_data({name, " rdata"}, exp_data, rdata);
		check_resp({name, " rresp"}, exp_resp, rresp);
		repeat (hold) begin
			@(negedge fft_clk);
			check_flag({name, " rvalid held"}, 1'b1, rvalid);
			check_flag({name, " arready while busy"}, 1'b0, arready);
			check_data({name, " rdata held"}, exp_data, rdata); // Stable under back-pressure
			check_resp({name, " rresp held"}, exp_resp, rresp);
		end
		@(posedge fft_clk);
		#DRIVE_DELAY;
		rready = 1'b1;
		@(posedge fft_clk); // Data beat taken
		#DRIVE_DELAY;
		rready = 1'b0;
		@(negedge fft_clk);
		check_flag({name, " rvalid after rready"}, 1'b0, rvalid);
	endtask

	// Compares every frame result with the queued prediction
	always @(negedge fft_clk) begin : compare_results
		string name;
		if (!reset && pitch_valid) begin
			if (exp_bin.size() == 0) begin
				stop_with_failure("pitch_valid pulsed although no frame result was expected");
			end else begin
				name = exp_name.pop_front();
				check_bin({name, " pitch_bin"}, exp_bin.pop_front(), pitch_bin);
				check_level({name, " peak_level"}, exp_level.pop_front(), peak_level);
				check_flag({name, " whistle"}, exp_whistle.pop_front(), whistle_detected);
				check_flag({name, " beep"}, exp_beep.pop_front(), beep_detected);
			end
		end else if (!reset) begin
			check_flag("whistle outside pitch_valid", 1'b0, whistle_detected); // Pulses only
			check_flag("beep outside pitch_valid", 1'b0, beep_detected);
		end
	end

	initial begin
		#(TIMEOUT);
		stop_with_failure($sformatf("Timeout, the run did not end within %0d time units",
			TIMEOUT));
	end

	initial begin : run_tests
		int unsigned seed;
		int amp;
		mag_t old_mag;
		int edge_bins [4];
		axi_addr_t addr_list [8];
		seed = 96886;
		void'($urandom(seed));
		reset = 1'b1;
		do_en = 1'b0;
		do_re = '0;
		do_im = '0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		edge_bins = '{5, 12, 20, 28};
		addr_list = '{0, 32, 98, 124, 128, 200, 252, 255};
		repeat (4) @(posedge fft_clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		idle_cycles(2);
		@(negedge fft_clk);
		check_flag("arready after reset", 1'b1, arready); // Read port idle
		check_flag("rvalid after reset", 1'b0, rvalid);
		check_flag("pitch_valid after reset", 1'b0, pitch_valid);

		read_and_check("read before first frame", 8'd0, 2, '0, RESP_SLVERR); // No frame yet

		// Single tones
		fill_noise(200);
		place_tone(8, 12000, -5000);
		send_frame("beep tone", 0);
		fill_noise(200);
		place_tone(24, -9000, 11000);
		send_frame("whistle tone", 0);
		idle_cycles(8);

		// Threshold edge, ties, upper half
		fill_noise(150);
		place_tone(7, 3709, 0); // Level 209
		send_frame("level below threshold", 1);
		fill_noise(150);
		place_tone(7, 3712, 0); // Level 210
		send_frame("level at threshold", 1);
		fill_noise(150);
		place_tone(9, 8000, 8000);
		place_tone(25, 8000, 8000);
		send_frame("tie keeps lower bin", 1);
		fill_noise(150);
		place_tone(40, 32767, 32767); // Above the half frame
		place_tone(24, 12000, 0);
		send_frame("upper half ignored", 1);
		idle_cycles(8);

		// Random frames back to back, then tones on the range bounds
		for (int i = 0; i < 6; i++) begin
			case ($urandom_range(2))
				0: amp = 300; // Quiet
				1: amp = 4000; // Near the threshold
				default: amp = 32767;
			endcase
			fill_noise(amp);
			send_frame($sformatf("random frame %0d", i), MAX_GAP);
		end
		for (int i = 0; i < 4; i++) begin
			fill_noise(200);
			place_tone(edge_bins[i], 15000, 3000);
			send_frame($sformatf("boundary bin %0d", edge_bins[i]), MAX_GAP);
		end
		idle_cycles(8);

		// Readout of the completed frame
		foreach (addr_list[i]) begin
			if (int'(addr_list[i]) < 4 * `FFT_NSAMPLES)
				read_and_check($sformatf("read addr %0d", addr_list[i]), addr_list[i],
					$urandom_range(3), frame_mag[addr_list[i] >> 2], RESP_OKAY);
			else
				read_and_check($sformatf("read addr %0d", addr_list[i]), addr_list[i],
					$urandom_range(3), '0, RESP_SLVERR);
		end

		// Read held across the next frame's bank swap
		old_mag = frame_mag[8];
		fill_noise(300);
		place_tone(8, -14000, 6000);
		fork
			begin
				send_frame("tone during readout", 0);
				idle_cycles(1);
			end
			read_and_check("read across bank swap", 8'd32, $urandom_range(70, 110),
				old_mag, RESP_OKAY);
		join
		idle_cycles(3);
		read_and_check("read after bank swap", 8'd32, $urandom_range(1, 5),
			frame_mag[8], RESP_OKAY);

		while (exp_bin.size() != 0) // Last results still in flight
			@(negedge fft_clk);
		idle_cycles(4);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
+incdir+test
logic/pitch_pkg.sv
logic/fft_mag_sq.sv
logic/fft_output_buffer.sv
logic/fft_find_peak.sv
logic/pitch_classifier.sv
logic/fft_pitch_detect.sv
test/tb_fft_pitch_detect.sv
